//--- design/axi_slave_pkg.sv
// AXI4 memory slave shared widths, burst codes, response codes and FSM encodings
`default_nettype none

package axi_slave_pkg;

    // Bus widths
    localparam int AXI_ID_W   = 4;
    localparam int AXI_ADDR_W = 32;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = 4;
    localparam int AXI_LEN_W  = 8;

    // Backing store geometry
    localparam int MEM_WORDS  = 256;
    localparam int MEM_ADDR_W = 8;

    localparam logic [1:0] BURST_FIXED = 2'd0;
    localparam logic [1:0] BURST_INCR  = 2'd1;
    localparam logic [1:0] BURST_WRAP  = 2'd2;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // Write engine states
    localparam logic [1:0] WR_ADDR = 2'd0;
    localparam logic [1:0] WR_DATA = 2'd1;
    localparam logic [1:0] WR_RESP = 2'd2;

    // Read engine states
    localparam logic [1:0] RD_IDLE    = 2'd0;
    localparam logic [1:0] RD_FETCH   = 2'd1;
    localparam logic [1:0] RD_WAIT    = 2'd2;
    localparam logic [1:0] RD_PRESENT = 2'd3;

endpackage

`default_nettype wire

//--- design/mem_wr_if.sv
// Memory write port bundle between the write engine and the word store
`default_nettype none

interface mem_wr_if
    import axi_slave_pkg::*;
();

    logic                  en;
    logic [MEM_ADDR_W-1:0] addr;
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;

    modport src (
        output en,
        output addr,
        output data,
        output strb
    );

    modport sink (
        input en,
        input addr,
        input data,
        input strb
    );

endinterface

`default_nettype wire

//--- design/axi_mem.sv
// Word memory with byte-strobed write port and registered read port
`default_nettype none

module axi_mem
    import axi_slave_pkg::*;
(
    input  logic                  aclk,
    mem_wr_if.sink                wr,
    input  logic                  rd_en,
    input  logic [MEM_ADDR_W-1:0] rd_addr,
    output logic [AXI_DATA_W-1:0] rd_data
);

    logic [AXI_DATA_W-1:0] mem [MEM_WORDS];

    // Per-byte write enables
    always_ff @(posedge aclk) begin
        for (int b = 0; b < AXI_STRB_W; b++) begin
            if (wr.en && wr.strb[b]) begin
                mem[wr.addr][8*b +: 8] <= wr.data[8*b +: 8];
            end
        end
    end

    // Same-cycle collision returns the old word
    always_ff @(posedge aclk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- design/axi_write_ctrl.sv
// AXI4 write channel engine covering AW, W and B with burst address walk
`default_nettype none

module axi_write_ctrl
    import axi_slave_pkg::*;
(
    input  logic                  aclk,
    input  logic                  arst_n,

    input  logic [AXI_ID_W-1:0]   awid,
    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic [AXI_LEN_W-1:0]  awlen,
    input  logic [1:0]            awburst,
    input  logic                  awvalid,
    output logic                  awready,

    input  logic [AXI_DATA_W-1:0] wdata,
    input  logic [AXI_STRB_W-1:0] wstrb,
    input  logic                  wlast,
    input  logic                  wvalid,
    output logic                  wready,

    output logic [AXI_ID_W-1:0]   bid,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,

    mem_wr_if.src                 mem
);

    logic [1:0]            state;
    logic [AXI_ID_W-1:0]   id_q;
    logic [MEM_ADDR_W-1:0] idx_q;
    logic [1:0]            burst_q;
    logic                  aw_fire;
    logic                  w_fire;

    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    assign wready = (state == WR_DATA);
    assign bvalid = (state == WR_RESP);
    assign bid    = id_q;
    assign bresp  = (burst_q == BURST_WRAP) ? RESP_SLVERR : RESP_OKAY;

    // WRAP beats are accepted but never reach memory
    assign mem.en   = w_fire && (burst_q != BURST_WRAP);
    assign mem.addr = idx_q;
    assign mem.data = wdata;
    assign mem.strb = wstrb;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= WR_ADDR;
            awready <= 1'b0;
        end else begin
            case (state)
                WR_ADDR: begin
                    if (aw_fire) begin
                        state   <= WR_DATA;
                        awready <= 1'b0;
                    end else begin
                        awready <= 1'b1;
                    end
                end
                WR_DATA: begin
                    if (w_fire && wlast) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (bready) begin
                        state   <= WR_ADDR;
                        awready <= 1'b1;
                    end
                end
                default: state <= WR_ADDR;
            endcase
        end
    end

    // Burst context captured on AW, index walks per beat
    always_ff @(posedge aclk) begin
        if (aw_fire) begin
            id_q    <= awid;
            idx_q   <= awaddr[MEM_ADDR_W+1:2];
            burst_q <= awburst;
        end else if (w_fire) begin
            if (burst_q == BURST_INCR) begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/axi_read_ctrl.sv
// AXI4 read channel engine covering AR and R with one memory fetch per beat
`default_nettype none

module axi_read_ctrl
    import axi_slave_pkg::*;
(
    input  logic                  aclk,
    input  logic                  arst_n,

    input  logic [AXI_ID_W-1:0]   arid,
    input  logic [AXI_ADDR_W-1:0] araddr,
    input  logic [AXI_LEN_W-1:0]  arlen,
    input  logic [1:0]            arburst,
    input  logic                  arvalid,
    output logic                  arready,

    output logic [AXI_ID_W-1:0]   rid,
    output logic [AXI_DATA_W-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rlast,
    output logic                  rvalid,
    input  logic                  rready,

    output logic                  rd_en,
    output logic [MEM_ADDR_W-1:0] rd_addr,
    input  logic [AXI_DATA_W-1:0] rd_data
);

    logic [1:0]            state;
    logic [AXI_ID_W-1:0]   id_q;
    logic [MEM_ADDR_W-1:0] idx_q;
    logic [1:0]            burst_q;
    logic [AXI_LEN_W-1:0]  cnt_q;
    logic                  ar_fire;
    logic                  r_fire;

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    assign rd_en   = (state == RD_FETCH);
    assign rd_addr = idx_q;
    assign rvalid  = (state == RD_PRESENT);
    assign rlast   = (cnt_q == '0);
    assign rid     = id_q;
    assign rresp   = (burst_q == BURST_WRAP) ? RESP_SLVERR : RESP_OKAY;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= RD_IDLE;
            arready <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        state   <= RD_FETCH;
                        arready <= 1'b0;
                    end else begin
                        arready <= 1'b1;
                    end
                end
                // Memory latches the word at the end of FETCH
                RD_FETCH: state <= RD_WAIT;
                RD_WAIT:  state <= RD_PRESENT;
                RD_PRESENT: begin
                    if (r_fire && rlast) begin
                        state   <= RD_IDLE;
                        arready <= 1'b1;
                    end else if (r_fire) begin
                        state <= RD_FETCH;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_fire) begin
            id_q    <= arid;
            idx_q   <= araddr[MEM_ADDR_W+1:2];
            burst_q <= arburst;
            cnt_q   <= arlen;
        end else if (r_fire) begin
            cnt_q <= cnt_q - 1'b1;
            if (burst_q == BURST_INCR) begin
                idx_q <= idx_q + 1'b1;
            end
        end
        // WRAP reads return zero
        if (state == RD_WAIT) begin
            rdata <= (burst_q == BURST_WRAP) ? '0 : rd_data;
        end
    end

endmodule

`default_nettype wire

//--- design/axi_slave_dut.sv
// AXI4 memory slave top joining the write engine, read engine and word store
`default_nettype none

module axi_slave_dut
    import axi_slave_pkg::*;
(
    input  logic                  aclk,
    input  logic                  arst_n,

    input  logic [AXI_ID_W-1:0]   awid,
    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic [AXI_LEN_W-1:0]  awlen,
    input  logic [1:0]            awburst,
    input  logic                  awvalid,
    output logic                  awready,

    input  logic [AXI_DATA_W-1:0] wdata,
    input  logic [AXI_STRB_W-1:0] wstrb,
    input  logic                  wlast,
    input  logic                  wvalid,
    output logic                  wready,

    output logic [AXI_ID_W-1:0]   bid,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,

    input  logic [AXI_ID_W-1:0]   arid,
    input  logic [AXI_ADDR_W-1:0] araddr,
    input  logic [AXI_LEN_W-1:0]  arlen,
    input  logic [1:0]            arburst,
    input  logic                  arvalid,
    output logic                  arready,

    output logic [AXI_ID_W-1:0]   rid,
    output logic [AXI_DATA_W-1:0] rdata,
    output logic [1:0]            rresp,
    output logic                  rlast,
    output logic                  rvalid,
    input  logic                  rready
);

    logic                  rd_en;
    logic [MEM_ADDR_W-1:0] rd_addr;
    logic [AXI_DATA_W-1:0] rd_data;

    mem_wr_if mem_wr_if_inst ();

    axi_write_ctrl axi_write_ctrl_inst (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .awid    (awid),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awburst (awburst),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wlast   (wlast),
        .wvalid  (wvalid),
        .wready  (wready),
        .bid     (bid),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .mem     (mem_wr_if_inst.src)
    );

    axi_read_ctrl axi_read_ctrl_inst (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arburst (arburst),
        .arvalid (arvalid),
        .arready (arready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    axi_mem axi_mem_inst (
        .aclk    (aclk),
        .wr      (mem_wr_if_inst.sink),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

//--- tests/top_tb.sv
// Self-checking testbench for the AXI4 memory slave against a reference memory model
`default_nettype none

module top_tb
    import axi_slave_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic                  aclk;
    logic                  arst_n;
    logic [AXI_ID_W-1:0]   awid;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic [AXI_LEN_W-1:0]  awlen;
    logic [1:0]            awburst;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_DATA_W-1:0] wdata;
    logic [AXI_STRB_W-1:0] wstrb;
    logic                  wlast;
    logic                  wvalid;
    logic                  wready;
    logic [AXI_ID_W-1:0]   bid;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [AXI_ID_W-1:0]   arid;
    logic [AXI_ADDR_W-1:0] araddr;
    logic [AXI_LEN_W-1:0]  arlen;
    logic [1:0]            arburst;
    logic                  arvalid;
    logic                  arready;
    logic [AXI_ID_W-1:0]   rid;
    logic [AXI_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rlast;
    logic                  rvalid;
    logic                  rready;

    logic [AXI_DATA_W-1:0]         ref_mem [MEM_WORDS];
    // Expected R beat packs {id, resp, last, data}, B packs {id, resp}
    logic [AXI_ID_W+AXI_DATA_W+2:0] r_exp [$];
    logic [AXI_ID_W+1:0]            b_exp [$];
    integer seed = 32'hc38d;
    int     errors = 0;
    int     test_errs = 0;
    int     r_beats = 0;
    int     b_resps = 0;

    axi_slave_dut axi_slave_dut_inst (.*);

    initial aclk = 1'b0;
    always #50 aclk = ~aclk;

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [AXI_DATA_W-1:0] ref_merge(input logic [AXI_DATA_W-1:0] old_word,
                                                        input logic [AXI_DATA_W-1:0] new_word,
                                                        input logic [AXI_STRB_W-1:0] strb,
                                                        input logic [1:0] burst);
        logic [AXI_DATA_W-1:0] merged;
        merged = old_word;
        if (burst != BURST_WRAP) begin
            for (int b = 0; b < AXI_STRB_W; b++) begin
                if (strb[b]) begin
                    merged[8*b +: 8] = new_word[8*b +: 8];
                end
            end
        end
        return merged;
    endfunction

    function automatic logic [1:0] ref_resp(input logic [1:0] burst);
        return (burst == BURST_WRAP) ? RESP_SLVERR : RESP_OKAY;
    endfunction

    task automatic write_burst(input logic [AXI_ID_W-1:0] id, input logic [AXI_ADDR_W-1:0] addr,
                               input int len, input logic [1:0] burst,
                               input bit part_strb, input bit backp);
        logic [MEM_ADDR_W-1:0] idx;
        logic [AXI_DATA_W-1:0] d;
        logic [AXI_STRB_W-1:0] s;
        idx = addr[MEM_ADDR_W+1:2];
        b_exp.push_back({id, ref_resp(burst)});
        awid    <= id;
        awaddr  <= addr;
        awlen   <= len - 1;
        awburst <= burst;
        awvalid <= 1'b1;
        do @(posedge aclk); while (!awready);
        awvalid <= 1'b0;
        for (int beat = 0; beat < len; beat++) begin
            repeat (backp ? rand_below(3) : 0) begin
                wvalid <= 1'b0;
                @(posedge aclk);
            end
            d = $random(seed);
            s = part_strb ? $random(seed) : '1;
            wdata  <= d;
            wstrb  <= s;
            wlast  <= (beat == len - 1);
            wvalid <= 1'b1;
            do @(posedge aclk); while (!wready);
            ref_mem[idx] = ref_merge(ref_mem[idx], d, s, burst);
            if (burst == BURST_INCR) begin
                idx = idx + 1'b1;
            end
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
        do begin
            bready <= backp ? 1'($random(seed)) : 1'b1;
            @(posedge aclk);
        end while (!(bvalid && bready));
        bready <= 1'b0;
    endtask

    task automatic read_burst(input logic [AXI_ID_W-1:0] id, input logic [AXI_ADDR_W-1:0] addr,
                              input int len, input logic [1:0] burst, input bit backp);
        logic [MEM_ADDR_W-1:0] idx;
        logic [AXI_DATA_W-1:0] d;
        int                    seen;
        idx = addr[MEM_ADDR_W+1:2];
        for (int beat = 0; beat < len; beat++) begin
            d = (burst == BURST_WRAP) ? '0 : ref_mem[idx];
            r_exp.push_back({id, ref_resp(burst), beat == len - 1, d});
            if (burst == BURST_INCR) begin
                idx = idx + 1'b1;
            end
        end
        arid    <= id;
        araddr  <= addr;
        arlen   <= len - 1;
        arburst <= burst;
        arvalid <= 1'b1;
        do @(posedge aclk); while (!arready);
        arvalid <= 1'b0;
        seen = 0;
        while (seen < len) begin
            rready <= backp ? 1'($random(seed)) : 1'b1;
            @(posedge aclk);
            if (rvalid && rready) begin
                seen++;
            end
        end
        rready <= 1'b0;
    endtask

    task automatic end_test(input string name);
        repeat (2) @(posedge aclk);
        assert (r_exp.size() == 0 && b_exp.size() == 0) else begin
            errors++;
            $display("%0t: %0d R beats and %0d B responses never arrived",
                     $time, r_exp.size(), b_exp.size());
        end
        $display("%s: %0d errors", name, errors - test_errs);
        test_errs = errors;
    endtask

    // Every R and B handshake is checked against the head of its queue
    always @(posedge aclk) begin : compare
        logic [AXI_ID_W+AXI_DATA_W+2:0] er;
        logic [AXI_ID_W+1:0]            eb;
        if (arst_n && rvalid && rready) begin
            if (r_exp.size() == 0) begin
                errors++;
                $display("%0t: R beat arrived when none was expected", $time);
            end else begin
                er = r_exp.pop_front();
                r_beats++;
                assert ({rid, rresp, rlast, rdata} === er) else begin
                    errors++;
                    $display("Mismatch at %0t: R id %h resp %0d last %b data %h, expected %h",
                             $time, rid, rresp, rlast, rdata, er);
                end
            end
        end
        if (arst_n && bvalid && bready) begin
            if (b_exp.size() == 0) begin
                errors++;
                $display("%0t: B response arrived when none was expected", $time);
            end else begin
                eb = b_exp.pop_front();
                b_resps++;
                assert ({bid, bresp} === eb) else begin
                    errors++;
                    $display("Mismatch at %0t: B id %h resp %0d, expected id %h resp %0d",
                             $time, bid, bresp, eb[AXI_ID_W+1:2], eb[1:0]);
                end
            end
        end
    end

    initial begin : watchdog
        int max_beats;
        // Preload, INCR pairs, strobe pairs, FIXED, WRAP, mixed
        max_beats = 256 + 8 * 2 * 16 + 8 * 2 * 4 + 8 + 12 + 30 * 16;
        repeat (20 * max_beats + 200) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d cycles", 20 * max_beats + 200);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin : stimulus
        logic [AXI_ADDR_W-1:0] addr;
        int                    len;
        logic [AXI_ID_W-1:0]   id;
        logic [1:0]            burst;
        arst_n = 1'b0;
        {awid, awaddr, awlen, awburst, awvalid, wdata, wstrb, wlast, wvalid, bready} = '0;
        {arid, araddr, arlen, arburst, arvalid, rready} = '0;

        // Registers take their reset values on the first edge
        @(posedge aclk);
        repeat (7) begin
            @(posedge aclk);
            assert (!awready && !wready && !bvalid && !arready && !rvalid) else begin
                errors++;
                $display("Mismatch at %0t: ready or valid high during reset", $time);
            end
        end
        arst_n <= 1'b1;
        @(posedge aclk);
        assert (!awready && !wready && !bvalid && !arready && !rvalid) else begin
            errors++;
            $display("Mismatch at %0t: ready or valid high on first edge after reset", $time);
        end
        @(posedge aclk);
        assert (awready && arready) else begin
            errors++;
            $display("Mismatch at %0t: awready or arready low after reset", $time);
        end
        end_test("test 1 reset values");

        // Whole memory gets defined contents first
        write_burst(0, 0, MEM_WORDS, BURST_INCR, 0, 0);
        repeat (8) begin
            id   = $random(seed);
            addr = $random(seed) & 32'h3fc;
            len  = 1 + rand_below(16);
            write_burst(id, addr, len, BURST_INCR, 0, 0);
            read_burst(id, addr, len, BURST_INCR, 0);
        end
        end_test("test 2 incr bursts");

        repeat (8) begin
            addr = $random(seed) & 32'h3fc;
            len  = 1 + rand_below(4);
            write_burst($random(seed), addr, len, BURST_INCR, 1, 0);
            read_burst($random(seed), addr, len, BURST_INCR, 0);
        end
        end_test("test 3 partial strobes");

        addr = $random(seed) & 32'h3fc;
        write_burst(4'h5, addr, 4, BURST_FIXED, 1, 0);
        read_burst(4'h6, addr, 4, BURST_FIXED, 0);
        end_test("test 4 fixed bursts");

        addr = $random(seed) & 32'h3fc;
        write_burst(4'h9, addr, 4, BURST_WRAP, 1, 0);
        read_burst(4'ha, addr, 4, BURST_INCR, 0);
        read_burst(4'hb, addr, 4, BURST_WRAP, 0);
        end_test("test 5 wrap bursts");

        // Full 32-bit addresses exercise aliasing above bit 9
        repeat (30) begin
            id    = $random(seed);
            addr  = $random(seed);
            len   = 1 + rand_below(16);
            burst = rand_below(3);
            if (rand_below(2) == 0) begin
                write_burst(id, addr, len, burst, 1, 1);
            end else begin
                read_burst(id, addr, len, burst, 1);
            end
        end
        end_test("test 6 mixed with back-pressure");

        $display("Checked %0d R beats and %0d B responses, %0d errors", r_beats, b_resps, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
design/axi_slave_pkg.sv
design/mem_wr_if.sv
design/axi_mem.sv
design/axi_write_ctrl.sv
design/axi_read_ctrl.sv
design/axi_slave_dut.sv
tests/top_tb.sv
